/* engine_pkg.sv */
// engine constants, bus indices, configuration types and host request type
package engine_pkg;

   // data path sizes
   localparam int data_w     = 32;
   localparam int mem_addr_w = 8;
   localparam int n_mem      = 2;
   localparam int n_fu       = 3;
   localparam int n_port     = 2 * n_mem;
   localparam int n_slot     = n_port + n_fu;
   localparam int slot_w     = 3;
   localparam int sel_w      = 4;
   localparam int bus_n      = 16;

   // data bus layout
   localparam int bus_zero     = 0;
   localparam int bus_one      = 1;
   localparam int bus_mem_base = 2;
   localparam int bus_fu_base  = bus_mem_base + n_port;

   // host address map
   localparam int ctr_addr_w = 11;
   localparam int region_w   = 2;

   // whole data bus, entry i is bus[i]
   typedef logic [bus_n-1:0][data_w-1:0] data_bus_t;

   typedef enum logic [2:0] {
      op_add,
      op_sub,
      op_and,
      op_or,
      op_xor,
      op_mul,
      op_max,
      op_pass
   } fu_op_e;

   // memory port view, 30 bits used
   typedef struct packed {
      logic                  enable;
      logic                  write;
      logic [sel_w-1:0]      sel;
      logic [mem_addr_w-1:0] start;
      logic [3:0]            incr;
      logic [7:0]            iter;
      logic [3:0]            delay;
      logic [1:0]            pad;
   } port_conf_t;

   // functional unit view
   typedef struct packed {
      fu_op_e           op;
      logic [sel_w-1:0] sel_a;
      logic [sel_w-1:0] sel_b;
      logic [20:0]      pad;
   } fu_conf_t;

   // one configuration word, read as a port or as an fu
   typedef union packed {
      port_conf_t  port;
      fu_conf_t    fu;
      logic [31:0] raw;
   } conf_word_u;

   // slots 0..3 are ports, 4..6 are fus
   typedef conf_word_u [n_slot-1:0] conf_array_t;

   // top bits of the host address
   typedef enum logic [region_w-1:0] {
      reg_mem0,
      reg_mem1,
      reg_conf,
      reg_ctrl
   } region_e;

   typedef struct packed {
      logic                  valid;
      logic                  we;
      logic [ctr_addr_w-1:0] addr;
      logic [data_w-1:0]     wdata;
   } host_req_t;

endpackage

/* engine_conf_regs.sv */
// staging configuration slots with readback and the shadow copy used during a run
`timescale 1ns/10ps

module engine_conf_regs (
   input  logic                               rst,   // clock
   input  logic                               clk,   // async reset
   input  logic                               conf_we,
   input  logic [engine_pkg::slot_w-1:0]      slot,
   input  engine_pkg::conf_word_u             wdata,
   input  logic                               run_pulse,
   output engine_pkg::conf_word_u             rdata,
   output engine_pkg::conf_array_t            active
);
   import engine_pkg::*;

   conf_array_t staging;
   logic        slot_ok;

   // slot 7 does not exist
   assign slot_ok = (slot < n_slot);

   // host side copy, written at any time
   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         staging <= '0;
      end else if (conf_we && slot_ok) begin
         staging[slot] <= wdata;
      end
   end

   // shadow copy steers the datapath for the whole run
   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         active <= '0;
      end else if (run_pulse) begin
         active <= staging;
      end
   end

   // readback is combinational, host_if registers it
   always_comb begin
      rdata = '0;
      if (slot_ok) begin
         rdata = staging[slot];
      end
   end

endmodule

/* engine_mem_unit.sv */
// dual-port data memory with two address generators and host access on port a
`timescale 1ns/10ps

module engine_mem_unit (
   input  logic                                rst,   // clock
   input  logic                                clk,   // async reset
   input  logic                                host_we,
   input  logic                                host_rd,
   input  logic [engine_pkg::mem_addr_w-1:0]   host_addr,
   input  logic [engine_pkg::data_w-1:0]       host_wdata,
   output logic [engine_pkg::data_w-1:0]       host_rdata,
   input  logic                                run_pulse,
   input  engine_pkg::port_conf_t              conf_a,
   input  engine_pkg::port_conf_t              conf_b,
   input  engine_pkg::data_bus_t               bus,
   output logic [engine_pkg::data_w-1:0]       out_a,
   output logic [engine_pkg::data_w-1:0]       out_b,
   output logic                                done
);
   import engine_pkg::*;

   logic [data_w-1:0] mem [2**mem_addr_w];

   port_conf_t [1:0]                 conf;
   logic [1:0]                       issue;
   logic [1:0]                       fin;
   logic [1:0][mem_addr_w-1:0]       port_addr;
   logic [1:0][mem_addr_w-1:0]       mem_addr;
   logic [1:0][data_w-1:0]           rd_q;
   logic                             host_sel;

   assign conf = {conf_b, conf_a};

   // one address generator per port
   for (genvar p = 0; p < 2; p++) begin : g_port
      logic [3:0]            dly_cnt;
      logic [7:0]            it_cnt;
      logic [mem_addr_w-1:0] offset;

      // issue after delay cycles, iter addresses in a row
      assign issue[p] = conf[p].enable && (dly_cnt == conf[p].delay) &&
                        (it_cnt != conf[p].iter);
      assign fin[p]   = !conf[p].enable || (it_cnt == conf[p].iter);

      // wraps modulo 256
      assign port_addr[p] = conf[p].start + offset;

      always_ff @(posedge rst or posedge clk) begin
         if (clk) begin
            dly_cnt <= '0;
            it_cnt  <= '0;
            offset  <= '0;
         end else if (run_pulse) begin
            dly_cnt <= '0;
            it_cnt  <= '0;
            offset  <= '0;
         end else if (conf[p].enable) begin
            if (dly_cnt != conf[p].delay) begin
               dly_cnt <= dly_cnt + 4'd1;
            end else if (issue[p]) begin
               it_cnt <= it_cnt + 8'd1;
               offset <= offset + mem_addr_w'(conf[p].incr);
            end
         end
      end
   end

   // host borrows port a while the engine is idle
   assign host_sel    = host_we || host_rd;
   assign mem_addr[0] = host_sel ? host_addr : port_addr[0];
   assign mem_addr[1] = port_addr[1];

   always_ff @(posedge rst) begin
      if (host_we) begin
         mem[mem_addr[0]] <= host_wdata;
      end
      for (int p = 0; p < 2; p++) begin
         if (issue[p] && conf[p].write) begin
            mem[mem_addr[p]] <= bus[conf[p].sel];
         end
      end
   end

   // read words stay on the bus until the next read
   always_ff @(posedge rst) begin
      if (host_rd) begin
         host_rdata <= mem[mem_addr[0]];
      end
      for (int p = 0; p < 2; p++) begin
         if (issue[p] && !conf[p].write) begin
            rd_q[p] <= mem[mem_addr[p]];
         end
      end
   end

   assign out_a = rd_q[0];
   assign out_b = rd_q[1];
   assign done  = &fin;

endmodule

/* engine_fu.sv */
// functional unit with two bus operands and a registered result
`timescale 1ns/10ps

module engine_fu (
   input  logic                          rst,   // clock
   input  logic                          clk,   // async reset
   input  logic                          run_pulse,
   input  engine_pkg::fu_conf_t          conf,
   input  engine_pkg::data_bus_t         bus,
   output logic [engine_pkg::data_w-1:0] result
);
   import engine_pkg::*;

   logic [data_w-1:0] op_a;
   logic [data_w-1:0] op_b;
   logic [data_w-1:0] res_next;

   assign op_a = bus[conf.sel_a];
   assign op_b = bus[conf.sel_b];

   always_comb begin
      case (conf.op)
         op_add:  res_next = op_a + op_b;
         op_sub:  res_next = op_a - op_b;
         op_and:  res_next = op_a & op_b;
         op_or:   res_next = op_a | op_b;
         op_xor:  res_next = op_a ^ op_b;
         // low word of the product
         op_mul:  res_next = op_a * op_b;
         op_max:  res_next = ($signed(op_a) > $signed(op_b)) ? op_a : op_b;
         default: res_next = op_a;
      endcase
   end

   // one cycle from operands to bus
   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         result <= '0;
      end else if (run_pulse) begin
         result <= '0;
      end else begin
         result <= res_next;
      end
   end

endmodule

/* engine_host_if.sv */
// host address decoder, read data mux, run strobe and busy status
`timescale 1ns/10ps

module engine_host_if (
   input  logic                               rst,   // clock
   input  logic                               clk,   // async reset
   input  engine_pkg::host_req_t              req,
   input  logic [engine_pkg::data_w-1:0]      mem_rdata0,
   input  logic [engine_pkg::data_w-1:0]      mem_rdata1,
   input  engine_pkg::conf_word_u             conf_rdata,
   input  logic [engine_pkg::n_mem-1:0]       mem_done,
   output logic [engine_pkg::n_mem-1:0]       mem_we,
   output logic [engine_pkg::n_mem-1:0]       mem_rd,
   output logic                               conf_we,
   output logic                               run_pulse,
   output logic                               busy,
   output logic [engine_pkg::data_w-1:0]      ctr_data_out
);
   import engine_pkg::*;

   region_e           region;
   region_e           rd_region;
   logic              wr_strobe;
   logic              rd_strobe;
   logic [data_w-1:0] local_q;

   assign region    = region_e'(req.addr[ctr_addr_w-1 -: region_w]);
   assign wr_strobe = req.valid && req.we;
   assign rd_strobe = req.valid && !req.we;

   // memory regions map straight onto memory numbers
   always_comb begin
      for (int i = 0; i < n_mem; i++) begin
         mem_we[i] = wr_strobe && (region == region_e'(i));
         mem_rd[i] = rd_strobe && (region == region_e'(i));
      end
   end

   assign conf_we   = wr_strobe && (region == reg_conf);
   assign run_pulse = wr_strobe && (region == reg_ctrl) && req.wdata[0];

   // run restarts even while busy
   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         busy <= 1'b0;
      end else if (run_pulse) begin
         busy <= 1'b1;
      end else if (&mem_done) begin
         busy <= 1'b0;
      end
   end

   // remember what the last read asked for
   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         rd_region <= reg_ctrl;
         local_q   <= '0;
      end else if (rd_strobe) begin
         rd_region <= region;
         if (region == reg_conf) begin
            local_q <= conf_rdata.raw;
         end else if (region == reg_ctrl) begin
            local_q <= {{(data_w-1){1'b0}}, busy};
         end
      end
   end

   always_comb begin
      case (rd_region)
         reg_mem0: ctr_data_out = mem_rdata0;
         reg_mem1: ctr_data_out = mem_rdata1;
         default:  ctr_data_out = local_q;
      endcase
   end

endmodule

/* data_engine.sv */
// engine top level with data bus, host interface, configuration, memories and fus
`timescale 1ns/10ps

module data_engine (
   input  logic                          rst,   // clock
   input  logic                          clk,   // async reset
   input  engine_pkg::host_req_t         ctr_req,
   output logic [engine_pkg::data_w-1:0] ctr_data_out,
   output logic                          busy
);
   import engine_pkg::*;

   // every unit drives its own entries and reads all of them
   wire data_bus_t                       data_bus;
   wire [n_mem-1:0][data_w-1:0]          mem_rdata;
   wire [n_mem-1:0]                      mem_done;
   logic [n_mem-1:0]                     mem_we;
   logic [n_mem-1:0]                     mem_rd;
   logic                                 conf_we;
   logic                                 run_pulse;
   conf_word_u                           conf_rdata;
   conf_array_t                          active;

   // constants and unused entries
   assign data_bus[bus_zero]                       = '0;
   assign data_bus[bus_one]                        = data_w'(1);
   assign data_bus[bus_n-1:bus_fu_base+n_fu]       = '0;

   engine_host_if host_if_inst (
      .rst          (rst),
      .clk          (clk),
      .req          (ctr_req),
      .mem_rdata0   (mem_rdata[0]),
      .mem_rdata1   (mem_rdata[1]),
      .conf_rdata   (conf_rdata),
      .mem_done     (mem_done),
      .mem_we       (mem_we),
      .mem_rd       (mem_rd),
      .conf_we      (conf_we),
      .run_pulse    (run_pulse),
      .busy         (busy),
      .ctr_data_out (ctr_data_out)
   );

   engine_conf_regs conf_regs_inst (
      .rst       (rst),
      .clk       (clk),
      .conf_we   (conf_we),
      .slot      (ctr_req.addr[slot_w-1:0]),
      .wdata     (ctr_req.wdata),
      .run_pulse (run_pulse),
      .rdata     (conf_rdata),
      .active    (active)
   );

   // memory i owns slots 2i and 2i+1
   for (genvar i = 0; i < n_mem; i++) begin : g_mem
      engine_mem_unit mem_inst (
         .rst        (rst),
         .clk        (clk),
         .host_we    (mem_we[i]),
         .host_rd    (mem_rd[i]),
         .host_addr  (ctr_req.addr[mem_addr_w-1:0]),
         .host_wdata (ctr_req.wdata),
         .host_rdata (mem_rdata[i]),
         .run_pulse  (run_pulse),
         .conf_a     (active[2*i].port),
         .conf_b     (active[2*i+1].port),
         .bus        (data_bus),
         .out_a      (data_bus[bus_mem_base+2*i]),
         .out_b      (data_bus[bus_mem_base+2*i+1]),
         .done       (mem_done[i])
      );
   end

   for (genvar i = 0; i < n_fu; i++) begin : g_fu
      engine_fu fu_inst (
         .rst       (rst),
         .clk       (clk),
         .run_pulse (run_pulse),
         .conf      (active[n_port+i].fu),
         .bus       (data_bus),
         .result    (data_bus[bus_fu_base+i])
      );
   end

endmodule

/* tb_data_engine_util.svh */
// testbench helpers: lfsr, host access, busy polling, compare tasks and operation model
`ifndef TB_DATA_ENGINE_UTIL_SVH
`define TB_DATA_ENGINE_UTIL_SVH

// fibonacci lfsr, taps 32 22 2 1, one step per bit taken
function automatic logic [31:0] lfsr_take(input int n_bits);
   logic [31:0] value;
   logic        fb;
   value = '0;
   for (int i = 0; i < n_bits; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      value      = {value[30:0], fb};
   end
   return value;
endfunction

// region in the top bits, word or slot in the low byte
function automatic logic [ctr_addr_w-1:0] ctr_addr(input region_e region,
                                                   input logic [7:0] idx);
   return {region, 1'b0, idx};
endfunction

task automatic host_write(input region_e region, input logic [7:0] idx,
                          input logic [data_w-1:0] data);
   ctr_req.valid = 1'b1;
   ctr_req.we    = 1'b1;
   ctr_req.addr  = ctr_addr(region, idx);
   ctr_req.wdata = data;
   @(negedge rst);
   ctr_req.valid = 1'b0;
   ctr_req.we    = 1'b0;
endtask

// read data is registered at the edge after the strobe
task automatic host_read(input region_e region, input logic [7:0] idx,
                         output logic [data_w-1:0] data);
   ctr_req.valid = 1'b1;
   ctr_req.we    = 1'b0;
   ctr_req.addr  = ctr_addr(region, idx);
   ctr_req.wdata = '0;
   @(negedge rst);
   data          = ctr_data_out;
   ctr_req.valid = 1'b0;
endtask

task automatic wait_idle();
   int cycles;
   cycles = 0;
   while (busy && cycles < idle_limit) begin
      @(negedge rst);
      cycles++;
   end
   if (busy) begin
      error_count++;
      $display("run did not finish, busy still high after %0d cycles", cycles);
   end
endtask

task automatic compare_word(input string name, input logic [data_w-1:0] got,
                            input logic [data_w-1:0] exp);
   check_count++;
   if (got !== exp) begin
      error_count++;
      $display("Error: %s got 0x%08h expected 0x%08h", name, got, exp);
   end
endtask

task automatic compare_conf(input string name, input conf_word_u got, input conf_word_u exp);
   check_count++;
   if (got.raw !== exp.raw) begin
      error_count++;
      $display("Error: %s got 0x%08h expected 0x%08h", name, got.raw, exp.raw);
   end
endtask

task automatic compare_busy(input logic exp);
   check_count++;
   if (busy !== exp) begin
      error_count++;
      $display("Error: busy got 0x%0h expected 0x%0h", busy, exp);
   end
endtask

// what one functional unit should produce for a pair of operands
function automatic logic [data_w-1:0] ref_op(input fu_op_e op, input logic [data_w-1:0] a,
                                             input logic [data_w-1:0] b);
   case (op)
      op_add:  return a + b;
      op_sub:  return a - b;
      op_and:  return a & b;
      op_or:   return a | b;
      op_xor:  return a ^ b;
      op_mul:  return a * b;
      op_max:  return ($signed(a) < $signed(b)) ? b : a;
      default: return a;
   endcase
endfunction

`endif

/* tb_data_engine.sv */
// testbench top with clock, reset, dut, watchdog and directed tests
`timescale 1ns/10ps

module tb_data_engine;
   import engine_pkg::*;

   localparam int clk_period = 4;
   localparam int n_tests    = 6;
   // busy cycles of the vector add, chain, five short runs and two shadow runs
   localparam int run_len_sum     = 20 + 13 + 5 * 8 + 2 * 20;
   localparam int watchdog_cycles = (n_tests * 100 + run_len_sum) * 2;
   localparam int idle_limit      = 300;

   logic              rst;
   logic              clk;
   host_req_t         ctr_req;
   logic [data_w-1:0] ctr_data_out;
   logic              busy;

   logic [31:0]       lfsr_state = 32'hbafe_0c3f;
   int                error_count;
   int                check_count;
   int                tests_done;
   logic [data_w-1:0] x_vec [16];
   logic [data_w-1:0] y_vec [16];

   `include "tb_data_engine_util.svh"

   data_engine data_engine_inst (
      .rst          (rst),
      .clk          (clk),
      .ctr_req      (ctr_req),
      .ctr_data_out (ctr_data_out),
      .busy         (busy)
   );

   initial begin
      rst = 1'b0;
      forever #(clk_period / 2) rst = ~rst;
   end

   initial begin : watchdog
      #(watchdog_cycles * clk_period);
      $display("timeout: tests still running after %0d cycles", watchdog_cycles);
      $display("Finished with errors");
      $finish;
   end

   function automatic conf_word_u port_word(input logic write, input logic [sel_w-1:0] sel,
                                            input logic [7:0] start, input logic [3:0] incr,
                                            input logic [7:0] iter, input logic [3:0] delay);
      conf_word_u w;
      w             = '0;
      w.port.enable = 1'b1;
      w.port.write  = write;
      w.port.sel    = sel;
      w.port.start  = start;
      w.port.incr   = incr;
      w.port.iter   = iter;
      w.port.delay  = delay;
      return w;
   endfunction

   function automatic conf_word_u fu_word(input fu_op_e op, input logic [sel_w-1:0] sel_a,
                                          input logic [sel_w-1:0] sel_b);
      conf_word_u w;
      w          = '0;
      w.fu.op    = op;
      w.fu.sel_a = sel_a;
      w.fu.sel_b = sel_b;
      return w;
   endfunction

   // x from mem0 0 and y from mem0 64 go through fu0 into mem1 at dst
   function automatic conf_array_t vector_config(input fu_op_e op, input int n,
                                                 input logic [7:0] dst);
      conf_array_t cfg;
      cfg    = '0;
      cfg[0] = port_word(1'b0, 4'd0, 8'd0, 4'd1, 8'(n), 4'd0);
      cfg[1] = port_word(1'b0, 4'd0, 8'd64, 4'd1, 8'(n), 4'd0);
      // read takes one cycle and the fu one more
      cfg[2] = port_word(1'b1, 4'(bus_fu_base), dst, 4'd1, 8'(n), 4'd2);
      cfg[n_port] = fu_word(op, 4'(bus_mem_base), 4'(bus_mem_base + 1));
      return cfg;
   endfunction

   task automatic load_config(input conf_array_t cfg);
      for (int s = 0; s < n_slot; s++) begin
         host_write(reg_conf, 8'(s), cfg[s].raw);
      end
   endtask

   task automatic start_run();
      host_write(reg_ctrl, 8'd0, 32'd1);
   endtask

   task automatic load_vectors(input int n, input logic [7:0] dst);
      for (int k = 0; k < n; k++) begin
         x_vec[k] = lfsr_take(32);
         y_vec[k] = lfsr_take(32);
         host_write(reg_mem0, 8'(k), x_vec[k]);
         host_write(reg_mem0, 8'(64 + k), y_vec[k]);
         // stale destination word
         host_write(reg_mem1, dst + 8'(k), ~x_vec[k]);
      end
   endtask

   task automatic check_vectors(input fu_op_e op, input int n, input logic [7:0] dst);
      logic [data_w-1:0] data;
      for (int k = 0; k < n; k++) begin
         host_read(reg_mem1, dst + 8'(k), data);
         compare_word($sformatf("mem1[0x%02h]", dst + 8'(k)), data,
                      ref_op(op, x_vec[k], y_vec[k]));
      end
   endtask

   task automatic run_vectors(input fu_op_e op, input int n, input logic [7:0] dst);
      logic [data_w-1:0] data;
      load_vectors(n, dst);
      load_config(vector_config(op, n, dst));
      start_run();
      compare_busy(1'b1);
      // status read while the run is going
      host_read(reg_ctrl, 8'd0, data);
      compare_word("ctrl read", data, 32'd1);
      wait_idle();
      check_vectors(op, n, dst);
   endtask

   task automatic report_test(input string name, input int errors_before);
      tests_done++;
      if (error_count == errors_before) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, error_count - errors_before);
      end
   endtask

   task automatic test_reset_state();
      int                errs;
      logic [data_w-1:0] data;
      errs = error_count;
      compare_busy(1'b0);
      compare_word("ctr_data_out", ctr_data_out, '0);
      host_read(reg_ctrl, 8'd0, data);
      compare_word("ctrl read", data, '0);
      for (int s = 0; s < n_slot; s++) begin
         host_read(reg_conf, 8'(s), data);
         compare_conf($sformatf("slot %0d", s), conf_word_u'(data), '0);
      end
      report_test("reset state", errs);
   endtask

   task automatic test_mem_round_trip();
      int                errs;
      region_e           region;
      logic [7:0]        addrs [2][16];
      logic [data_w-1:0] model [2][256];
      logic [data_w-1:0] data;
      errs = error_count;
      for (int m = 0; m < n_mem; m++) begin
         region = (m == 0) ? reg_mem0 : reg_mem1;
         for (int i = 0; i < 16; i++) begin
            addrs[m][i]           = 8'(lfsr_take(8));
            data                  = lfsr_take(32);
            model[m][addrs[m][i]] = data;
            host_write(region, addrs[m][i], data);
         end
      end
      // repeated addresses hold the last word written
      for (int m = 0; m < n_mem; m++) begin
         region = (m == 0) ? reg_mem0 : reg_mem1;
         for (int i = 0; i < 16; i++) begin
            host_read(region, addrs[m][i], data);
            compare_word($sformatf("mem%0d[0x%02h]", m, addrs[m][i]), data,
                         model[m][addrs[m][i]]);
         end
      end
      report_test("memory round trip", errs);
   endtask

   task automatic test_conf_readback();
      int                errs;
      conf_array_t       cfg;
      logic [data_w-1:0] data;
      errs = error_count;
      cfg  = '0;
      for (int s = 0; s < n_port; s++) begin
         cfg[s].port.enable = 1'(lfsr_take(1));
         cfg[s].port.write  = 1'(lfsr_take(1));
         cfg[s].port.sel    = 4'(lfsr_take(4));
         cfg[s].port.start  = 8'(lfsr_take(8));
         cfg[s].port.incr   = 4'(lfsr_take(4));
         cfg[s].port.iter   = 8'(lfsr_take(8));
         cfg[s].port.delay  = 4'(lfsr_take(4));
      end
      for (int s = n_port; s < n_slot; s++) begin
         cfg[s].fu.op    = fu_op_e'(3'(lfsr_take(3)));
         cfg[s].fu.sel_a = 4'(lfsr_take(4));
         cfg[s].fu.sel_b = 4'(lfsr_take(4));
      end
      load_config(cfg);
      compare_busy(1'b0);
      for (int s = 0; s < n_slot; s++) begin
         host_read(reg_conf, 8'(s), data);
         compare_conf($sformatf("slot %0d", s), conf_word_u'(data), cfg[s]);
      end
      compare_busy(1'b0);
      report_test("configuration readback", errs);
   endtask

   task automatic test_vector_add();
      int errs;
      errs = error_count;
      run_vectors(op_add, 16, 8'd0);
      report_test("vector add", errs);
   endtask

   task automatic test_chain();
      int                errs;
      conf_array_t       cfg;
      logic [data_w-1:0] prior [16];
      logic [data_w-1:0] data;
      logic [data_w-1:0] exp;
      fu_op_e            short_ops [5] = '{op_and, op_or, op_xor, op_max, op_pass};
      errs = error_count;
      for (int k = 0; k < 8; k++) begin
         x_vec[k] = lfsr_take(32);
         y_vec[k] = lfsr_take(32);
         host_write(reg_mem0, 8'(k), x_vec[k]);
         host_write(reg_mem0, 8'(64 + 3 * k), y_vec[k]);
      end
      for (int i = 0; i < 16; i++) begin
         prior[i] = lfsr_take(32);
         host_write(reg_mem1, 8'(128 + i), prior[i]);
      end
      cfg    = '0;
      cfg[0] = port_word(1'b0, 4'd0, 8'd0, 4'd1, 8'd8, 4'd0);
      cfg[1] = port_word(1'b0, 4'd0, 8'd64, 4'd3, 8'd8, 4'd0);
      // read, mul and sub take three cycles to fu2
      cfg[3] = port_word(1'b1, 4'(bus_fu_base + 2), 8'd128, 4'd2, 8'd8, 4'd3);
      cfg[n_port + 1] = fu_word(op_mul, 4'(bus_mem_base), 4'(bus_mem_base + 1));
      cfg[n_port + 2] = fu_word(op_sub, 4'(bus_fu_base + 1), 4'(bus_one));
      load_config(cfg);
      start_run();
      compare_busy(1'b1);
      wait_idle();
      for (int i = 0; i < 16; i++) begin
         host_read(reg_mem1, 8'(128 + i), data);
         if (i % 2 == 0) begin
            exp = ref_op(op_sub, ref_op(op_mul, x_vec[i / 2], y_vec[i / 2]), 32'd1);
         end else begin
            exp = prior[i];
         end
         compare_word($sformatf("mem1[0x%02h]", 128 + i), data, exp);
      end
      for (int i = 0; i < 5; i++) begin
         run_vectors(short_ops[i], 4, 8'd200);
      end
      report_test("chained operations", errs);
   endtask

   task automatic test_shadow_isolation();
      int                errs;
      conf_word_u        next_fu;
      logic [data_w-1:0] data;
      errs    = error_count;
      next_fu = fu_word(op_xor, 4'(bus_mem_base), 4'(bus_mem_base + 1));
      load_vectors(16, 8'd0);
      load_config(vector_config(op_add, 16, 8'd0));
      start_run();
      compare_busy(1'b1);
      // staging changes but the running copy must not
      host_write(reg_conf, 8'(n_port), next_fu.raw);
      compare_busy(1'b1);
      wait_idle();
      check_vectors(op_add, 16, 8'd0);
      host_read(reg_conf, 8'(n_port), data);
      compare_conf("slot 4", conf_word_u'(data), next_fu);
      start_run();
      compare_busy(1'b1);
      wait_idle();
      check_vectors(op_xor, 16, 8'd0);
      report_test("shadow isolation", errs);
   endtask

   initial begin
      clk         = 1'b1;
      ctr_req     = '0;
      error_count = 0;
      check_count = 0;
      tests_done  = 0;
      repeat (5) @(posedge rst);
      @(negedge rst);
      clk = 1'b0;
      @(negedge rst);
      test_reset_state();
      test_mem_round_trip();
      test_conf_readback();
      test_vector_add();
      test_chain();
      test_shadow_isolation();
      $display("tests %0d, checks %0d, errors %0d", tests_done, check_count, error_count);
      if (error_count == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

/* data_engine.f */
+incdir+.
engine_pkg.sv
engine_conf_regs.sv
engine_mem_unit.sv
engine_fu.sv
engine_host_if.sv
data_engine.sv
tb_data_engine.sv

/* run_sim.sh */
#!/bin/sh
# build and run the data engine testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_data_engine -f data_engine.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vtb_data_engine)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "Finished with no errors"; then
   exit 0
fi
exit 1
